// File: verilog/phy_macros.svh
`ifndef PHY_MACROS_SVH
`define PHY_MACROS_SVH

// lane geometry
`define PHY_NUM_LANES 4
`define PHY_LANE_W 8
`define PHY_WORD_W 32

// x^16+x^5+x^4+x^3+1 scrambler
`define PHY_LFSR_W 16
`define PHY_LFSR_SEED 16'hffff

// receive buffer
`define PHY_FIFO_DEPTH 8
`define PHY_FIFO_AFULL 4 // leaves room for words still in flight

`endif

// File: verilog/phy_pkg.sv
`default_nettype none

`include "phy_macros.svh"

package phy_pkg;

  typedef logic [`PHY_WORD_W-1:0] word_t;
  typedef logic [`PHY_LANE_W-1:0] lane_byte_t;
  typedef logic [`PHY_NUM_LANES-1:0] lane_mask_t;
  typedef logic [`PHY_LFSR_W-1:0] lfsr_t;

  // active lane count
  typedef enum logic [1:0] {
    X1 = 2'd0,
    X2 = 2'd1,
    X4 = 2'd2
  } link_width_e;

  typedef enum logic {
    REG_WIDTH    = 1'b0,
    REG_SCRAMBLE = 1'b1
  } cfg_addr_e;

endpackage

`default_nettype wire

// File: verilog/lane_cfg_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "phy_macros.svh"

module lane_cfg_regs (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  logic                                        cfg_wr_i,
  input  phy_pkg::cfg_addr_e                          cfg_addr_i,
  input  logic [$bits(phy_pkg::link_width_e)-1:0]     cfg_wdata_i,
  output logic [$bits(phy_pkg::link_width_e)-1:0]     cfg_rdata_o,
  output phy_pkg::link_width_e                        link_width_o,
  output logic                                        scramble_en_o,
  output logic                                        lfsr_restart_o
);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      link_width_o   <= phy_pkg::X4;
      scramble_en_o  <= 1'b1;
      lfsr_restart_o <= 1'b0;
    end else begin
      lfsr_restart_o <= cfg_wr_i; // both directions reseed together
      if (cfg_wr_i) begin
        case (cfg_addr_i)
          phy_pkg::REG_WIDTH: begin
            // unused code 2'b11 falls back to full width
            if (cfg_wdata_i == 2'b11) link_width_o <= phy_pkg::X4;
            else link_width_o <= phy_pkg::link_width_e'(cfg_wdata_i);
          end
          default: scramble_en_o <= cfg_wdata_i[0];
        endcase
      end
    end
  end

  // readback
  always_comb begin
    case (cfg_addr_i)
      phy_pkg::REG_WIDTH: cfg_rdata_o = link_width_o;
      default:            cfg_rdata_o = {1'b0, scramble_en_o};
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/lane_striper.sv
`timescale 1ns/1ns
`default_nettype none

`include "phy_macros.svh"

module lane_striper (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  phy_pkg::word_t                                s_axis_tdata_i,
  input  logic                                          s_axis_tvalid_i,
  output logic                                          s_axis_tready_o,
  input  phy_pkg::link_width_e                          link_width_i,
  input  logic                                          fifo_afull_i,
  output phy_pkg::lane_byte_t [`PHY_NUM_LANES-1:0]      lane_data_o,
  output phy_pkg::lane_mask_t                           lane_valid_o
);

  phy_pkg::word_t      word_q;   // bytes not yet sent
  phy_pkg::word_t      src;
  phy_pkg::lane_mask_t lane_en;
  logic [1:0]          beat_q;   // beats still owed
  logic [1:0]          beats_m1;
  logic [5:0]          step_bits;
  logic                accept;
  logic                beat_go;

  always_comb begin
    case (link_width_i)
      phy_pkg::X1: begin
        lane_en   = 4'b0001;
        beats_m1  = 2'd3;
        step_bits = 6'd8;
      end
      phy_pkg::X2: begin
        lane_en   = 4'b0011;
        beats_m1  = 2'd1;
        step_bits = 6'd16;
      end
      default: begin
        lane_en   = 4'b1111;
        beats_m1  = 2'd0;
        step_bits = 6'd32;
      end
    endcase
  end

  assign s_axis_tready_o = (beat_q == 2'd0) && !fifo_afull_i;
  assign accept  = s_axis_tvalid_i && s_axis_tready_o;
  assign beat_go = accept || (beat_q != 2'd0);
  assign src     = accept ? s_axis_tdata_i : word_q; // beat 0 straight from input

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      beat_q       <= '0;
      lane_valid_o <= '0;
    end else begin
      if (accept) beat_q <= beats_m1;
      else if (beat_q != 2'd0) beat_q <= beat_q - 2'd1;
      lane_valid_o <= beat_go ? lane_en : '0;
    end
  end

  // lane l always takes byte l of the remaining word
  always_ff @(posedge clk_i) begin
    if (beat_go) begin
      word_q <= src >> step_bits;
      for (int l = 0; l < `PHY_NUM_LANES; l++) begin
        lane_data_o[l] <= src[l*`PHY_LANE_W +: `PHY_LANE_W];
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/lane_scrambler.sv
`timescale 1ns/1ns
`default_nettype none

`include "phy_macros.svh"

module lane_scrambler (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                restart_i,
  input  logic                scramble_en_i,
  input  phy_pkg::lane_byte_t data_i,
  input  logic                valid_i,
  output phy_pkg::lane_byte_t data_o,
  output logic                valid_o
);

  // taps for x^5, x^4, x^3 and the feedback into bit 0
  localparam phy_pkg::lfsr_t TAPS = 16'h0039;

  phy_pkg::lfsr_t      lfsr_q;
  phy_pkg::lfsr_t      lfsr_nxt;
  phy_pkg::lane_byte_t key;

  // eight steps, one per data bit, lsb first
  always_comb begin
    phy_pkg::lfsr_t s;
    s = lfsr_q;
    for (int b = 0; b < `PHY_LANE_W; b++) begin
      key[b] = s[`PHY_LFSR_W-1];
      s = {s[`PHY_LFSR_W-2:0], 1'b0} ^ ({`PHY_LFSR_W{s[`PHY_LFSR_W-1]}} & TAPS);
    end
    lfsr_nxt = s;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || restart_i) lfsr_q <= `PHY_LFSR_SEED;
    else if (valid_i) lfsr_q <= lfsr_nxt; // steps even with scrambling off
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) valid_o <= 1'b0;
    else valid_o <= valid_i;
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) data_o <= scramble_en_i ? (data_i ^ key) : data_i;
  end

endmodule

`default_nettype wire

// File: verilog/lane_packer.sv
`timescale 1ns/1ns
`default_nettype none

`include "phy_macros.svh"

module lane_packer (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  phy_pkg::link_width_e                       link_width_i,
  input  phy_pkg::lane_byte_t [`PHY_NUM_LANES-1:0]   lane_data_i,
  input  phy_pkg::lane_mask_t                        lane_valid_i,
  output logic                                       fifo_wr_o,
  output phy_pkg::word_t                             fifo_data_o
);

  phy_pkg::word_t acc_q;
  phy_pkg::word_t word_nxt;
  logic [1:0]     beat_q;
  logic [1:0]     beats_m1;
  logic [2:0]     nlanes;
  logic           beat_in;
  logic           last_beat;

  always_comb begin
    case (link_width_i)
      phy_pkg::X1: begin
        nlanes   = 3'd1;
        beats_m1 = 2'd3;
      end
      phy_pkg::X2: begin
        nlanes   = 3'd2;
        beats_m1 = 2'd1;
      end
      default: begin
        nlanes   = 3'd4;
        beats_m1 = 2'd0;
      end
    endcase
  end

  assign beat_in   = |lane_valid_i;
  assign last_beat = beat_in && (beat_q == beats_m1);

  // byte b*W+l comes from lane l in beat b
  always_comb begin
    int pos;
    word_nxt = acc_q;
    for (int l = 0; l < `PHY_NUM_LANES; l++) begin
      pos = int'(beat_q) * int'(nlanes) + l;
      if (lane_valid_i[l] && pos < `PHY_NUM_LANES) begin
        word_nxt[pos*`PHY_LANE_W +: `PHY_LANE_W] = lane_data_i[l];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      beat_q    <= '0;
      fifo_wr_o <= 1'b0;
    end else begin
      fifo_wr_o <= last_beat;
      if (last_beat) beat_q <= '0;
      else if (beat_in) beat_q <= beat_q + 2'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_in) acc_q <= word_nxt;
    if (last_beat) fifo_data_o <= word_nxt;
  end

endmodule

`default_nettype wire

// File: verilog/rx_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "phy_macros.svh"

module rx_fifo (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           wr_i,
  input  phy_pkg::word_t wdata_i,
  input  logic           rd_i,
  output phy_pkg::word_t rdata_o,
  output logic           empty_o,
  output logic           almost_full_o
);

  localparam int AW = $clog2(`PHY_FIFO_DEPTH);

  phy_pkg::word_t mem [`PHY_FIFO_DEPTH];
  logic [AW-1:0]  wr_ptr_q;
  logic [AW-1:0]  rd_ptr_q;
  logic [AW:0]    count_q;
  logic           full;
  logic           do_wr;
  logic           do_rd;

  assign full          = (count_q == (AW+1)'(`PHY_FIFO_DEPTH));
  assign empty_o       = (count_q == '0);
  assign almost_full_o = (count_q >= (AW+1)'(`PHY_FIFO_AFULL));
  assign do_wr         = wr_i && !full;
  assign do_rd         = rd_i && !empty_o;

  assign rdata_o = mem[rd_ptr_q]; // show-ahead

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_wr) wr_ptr_q <= wr_ptr_q + 1'b1; // depth is a power of two
      if (do_rd) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_wr) mem[wr_ptr_q] <= wdata_i;
  end

endmodule

`default_nettype wire

// File: verilog/phy_datapath_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "phy_macros.svh"

module phy_datapath_top (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  // input stream
  input  phy_pkg::word_t                              s_axis_tdata_i,
  input  logic                                        s_axis_tvalid_i,
  output logic                                        s_axis_tready_o,
  // output stream
  output phy_pkg::word_t                              m_axis_tdata_o,
  output logic                                        m_axis_tvalid_o,
  input  logic                                        m_axis_tready_i,
  // configuration
  input  logic                                        cfg_wr_i,
  input  phy_pkg::cfg_addr_e                          cfg_addr_i,
  input  logic [$bits(phy_pkg::link_width_e)-1:0]     cfg_wdata_i,
  output logic [$bits(phy_pkg::link_width_e)-1:0]     cfg_rdata_o,
  // lanes
  output phy_pkg::lane_byte_t [`PHY_NUM_LANES-1:0]    tx_lane_data_o,
  output phy_pkg::lane_mask_t                         tx_lane_valid_o,
  input  phy_pkg::lane_byte_t [`PHY_NUM_LANES-1:0]    rx_lane_data_i,
  input  phy_pkg::lane_mask_t                         rx_lane_valid_i
);

  phy_pkg::link_width_e                     link_width;
  logic                                     scramble_en;
  logic                                     lfsr_restart;
  phy_pkg::lane_byte_t [`PHY_NUM_LANES-1:0] plain_data;
  phy_pkg::lane_mask_t                      plain_valid;
  phy_pkg::lane_byte_t [`PHY_NUM_LANES-1:0] rx_data;
  phy_pkg::lane_mask_t                      rx_valid;
  phy_pkg::word_t                           fifo_wdata;
  logic                                     fifo_wr;
  logic                                     fifo_rd;
  logic                                     fifo_empty;
  logic                                     fifo_afull;

  lane_cfg_regs u_cfg_regs (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .cfg_wr_i       (cfg_wr_i),
    .cfg_addr_i     (cfg_addr_i),
    .cfg_wdata_i    (cfg_wdata_i),
    .cfg_rdata_o    (cfg_rdata_o),
    .link_width_o   (link_width),
    .scramble_en_o  (scramble_en),
    .lfsr_restart_o (lfsr_restart)
  );

  lane_striper u_striper (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .s_axis_tdata_i  (s_axis_tdata_i),
    .s_axis_tvalid_i (s_axis_tvalid_i),
    .s_axis_tready_o (s_axis_tready_o),
    .link_width_i    (link_width),
    .fifo_afull_i    (fifo_afull),
    .lane_data_o     (plain_data),
    .lane_valid_o    (plain_valid)
  );

  for (genvar lane = 0; lane < `PHY_NUM_LANES; lane++) begin : gen_lane
    lane_scrambler u_tx_scr (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .restart_i     (lfsr_restart),
      .scramble_en_i (scramble_en),
      .data_i        (plain_data[lane]),
      .valid_i       (plain_valid[lane]),
      .data_o        (tx_lane_data_o[lane]),
      .valid_o       (tx_lane_valid_o[lane])
    );

    // same key stream undoes the scrambling
    lane_scrambler u_rx_scr (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .restart_i     (lfsr_restart),
      .scramble_en_i (scramble_en),
      .data_i        (rx_lane_data_i[lane]),
      .valid_i       (rx_lane_valid_i[lane]),
      .data_o        (rx_data[lane]),
      .valid_o       (rx_valid[lane])
    );
  end

  lane_packer u_packer (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .link_width_i (link_width),
    .lane_data_i  (rx_data),
    .lane_valid_i (rx_valid),
    .fifo_wr_o    (fifo_wr),
    .fifo_data_o  (fifo_wdata)
  );

  rx_fifo u_rx_fifo (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .wr_i          (fifo_wr),
    .wdata_i       (fifo_wdata),
    .rd_i          (fifo_rd),
    .rdata_o       (m_axis_tdata_o),
    .empty_o       (fifo_empty),
    .almost_full_o (fifo_afull)
  );

  assign m_axis_tvalid_o = !fifo_empty;
  assign fifo_rd         = m_axis_tvalid_o && m_axis_tready_i;

endmodule

`default_nettype wire

// File: tb/phy_datapath_chk.sv
`timescale 1ns/1ns
`default_nettype none

`include "phy_macros.svh"

module phy_datapath_chk (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 fifo_wr_i,
  input  logic                 fifo_rd_i,
  input  phy_pkg::link_width_e link_width_i,
  input  phy_pkg::lane_mask_t  tx_lane_valid_i,
  input  phy_pkg::word_t       m_axis_tdata_i,
  input  logic                 m_axis_tvalid_i,
  input  logic                 m_axis_tready_i
);

  int unsigned         fail_cnt = 0;
  logic [3:0]          fill_q;    // words held in the FIFO
  phy_pkg::lane_mask_t lane_mask;

  always @(posedge clk_i) begin
    if (!rst_n_i) fill_q <= '0;
    else begin
      case ({fifo_wr_i, fifo_rd_i})
        2'b10:   fill_q <= fill_q + 4'd1;
        2'b01:   fill_q <= fill_q - 4'd1;
        default: fill_q <= fill_q;
      endcase
    end
  end

  always_comb begin
    case (link_width_i)
      phy_pkg::X1: lane_mask = 4'b0001;
      phy_pkg::X2: lane_mask = 4'b0011;
      default:     lane_mask = 4'b1111;
    endcase
  end

  no_write_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(fifo_wr_i && fill_q == 4'(`PHY_FIFO_DEPTH)))
    else begin
      fail_cnt++;
      $error("receive FIFO written while full");
    end

  inactive_lanes_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (tx_lane_valid_i & ~lane_mask) == '0)
    else begin
      fail_cnt++;
      $error("transmit valid on a lane above the link width");
    end

  output_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (m_axis_tvalid_i && !m_axis_tready_i) |=> (m_axis_tvalid_i && $stable(m_axis_tdata_i)))
    else begin
      fail_cnt++;
      $error("output word changed while stalled");
    end

endmodule

bind phy_datapath_top phy_datapath_chk u_chk (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .fifo_wr_i       (fifo_wr),
  .fifo_rd_i       (fifo_rd),
  .link_width_i    (link_width),
  .tx_lane_valid_i (tx_lane_valid_o),
  .m_axis_tdata_i  (m_axis_tdata_o),
  .m_axis_tvalid_i (m_axis_tvalid_o),
  .m_axis_tready_i (m_axis_tready_i)
);

`default_nettype wire

// File: tb/tb_phy_datapath.sv
`timescale 1ns/1ns
`default_nettype none

`include "phy_macros.svh"

module tb_phy_datapath;

  localparam int WAIT_LIMIT = 2000;
  localparam int PAT_LEN    = 1024;
  localparam int STALL_RUN  = 24;

  logic                                     clk_i;
  logic                                     rst_n_i;
  phy_pkg::word_t                           s_axis_tdata_i;
  logic                                     s_axis_tvalid_i;
  logic                                     s_axis_tready_o;
  phy_pkg::word_t                           m_axis_tdata_o;
  logic                                     m_axis_tvalid_o;
  logic                                     m_axis_tready_i;
  logic                                     cfg_wr_i;
  phy_pkg::cfg_addr_e                       cfg_addr_i;
  logic [1:0]                               cfg_wdata_i;
  logic [1:0]                               cfg_rdata_o;
  phy_pkg::lane_byte_t [`PHY_NUM_LANES-1:0] tx_lane_data_o;
  phy_pkg::lane_mask_t                      tx_lane_valid_o;
  phy_pkg::lane_byte_t [`PHY_NUM_LANES-1:0] rx_lane_data_i;
  phy_pkg::lane_mask_t                      rx_lane_valid_i;

  // reference model
  phy_pkg::word_t      exp_q [$];
  phy_pkg::lane_byte_t lane_q [`PHY_NUM_LANES][$]; // plain bytes per lane
  phy_pkg::lfsr_t      lfsr_m [`PHY_NUM_LANES];
  int                  width_m;
  logic                scr_m;

  logic [1:0] ready_mode; // 0 random, 1 low, 2 high
  bit         ready_pat [PAT_LEN];
  int         cyc = 0;
  int         beat_cnt;
  int         errors;
  int         checks;
  int         tests;
  int         failed;
  event       abort_ev;

  phy_datapath_top UUT (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .s_axis_tdata_i  (s_axis_tdata_i),
    .s_axis_tvalid_i (s_axis_tvalid_i),
    .s_axis_tready_o (s_axis_tready_o),
    .m_axis_tdata_o  (m_axis_tdata_o),
    .m_axis_tvalid_o (m_axis_tvalid_o),
    .m_axis_tready_i (m_axis_tready_i),
    .cfg_wr_i        (cfg_wr_i),
    .cfg_addr_i      (cfg_addr_i),
    .cfg_wdata_i     (cfg_wdata_i),
    .cfg_rdata_o     (cfg_rdata_o),
    .tx_lane_data_o  (tx_lane_data_o),
    .tx_lane_valid_o (tx_lane_valid_o),
    .rx_lane_data_i  (rx_lane_data_i),
    .rx_lane_valid_i (rx_lane_valid_i)
  );

  // external loopback
  assign rx_lane_data_i  = tx_lane_data_o;
  assign rx_lane_valid_i = tx_lane_valid_o;

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    case (ready_mode)
      2'd0:    m_axis_tready_i <= ready_pat[cyc % PAT_LEN];
      2'd1:    m_axis_tready_i <= 1'b0;
      default: m_axis_tready_i <= 1'b1;
    endcase
  end

  // x^16+x^5+x^4+x^3+1, shifting towards bit 15
  function automatic phy_pkg::lfsr_t lfsr_step(input phy_pkg::lfsr_t s);
    logic           fb;
    phy_pkg::lfsr_t n;
    fb   = s[`PHY_LFSR_W-1];
    n    = {s[`PHY_LFSR_W-2:0], fb};
    n[3] = n[3] ^ fb;
    n[4] = n[4] ^ fb;
    n[5] = n[5] ^ fb;
    return n;
  endfunction

  function automatic phy_pkg::lane_byte_t next_key(inout phy_pkg::lfsr_t state);
    phy_pkg::lane_byte_t key;
    for (int b = 0; b < `PHY_LANE_W; b++) begin
      key[b] = state[`PHY_LFSR_W-1]; // lsb first
      state  = lfsr_step(state);
    end
    return key;
  endfunction

  function automatic int lanes_pending();
    int n;
    n = 0;
    for (int l = 0; l < `PHY_NUM_LANES; l++) n += lane_q[l].size();
    return n;
  endfunction

  task automatic compare_word(input string name, input phy_pkg::word_t got,
                              input phy_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_lane_byte(input string name, input phy_pkg::lane_byte_t got,
                                   input phy_pkg::lane_byte_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_reg(input string name, input logic [1:0] got, input logic [1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic compare_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERROR at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("problem at %0t ns: %s", $time, msg);
  endtask

  task automatic abort_run(input string msg);
    errors++;
    $display("timeout at %0t ns: %s", $time, msg);
    -> abort_ev;
  endtask

  // tracks accepted words, lane bytes and delivered words
  always @(posedge clk_i) begin : monitor
    phy_pkg::lane_byte_t plain;
    phy_pkg::lane_byte_t key;
    if (rst_n_i) begin
      if (s_axis_tvalid_i && s_axis_tready_o) begin
        exp_q.push_back(s_axis_tdata_i);
        for (int i = 0; i < `PHY_NUM_LANES; i++) begin
          lane_q[i % width_m].push_back(s_axis_tdata_i[i*`PHY_LANE_W +: `PHY_LANE_W]);
        end
      end
      if (|tx_lane_valid_o) beat_cnt++;
      for (int l = 0; l < `PHY_NUM_LANES; l++) begin
        if (!tx_lane_valid_o[l]) continue;
        if (l >= width_m) begin
          report_problem($sformatf("lane %0d is valid above the link width", l));
        end else if (lane_q[l].size() == 0) begin
          report_problem($sformatf("lane %0d sent a byte that was never striped", l));
        end else begin
          plain = lane_q[l].pop_front();
          key   = next_key(lfsr_m[l]); // steps even with scrambling off
          compare_lane_byte($sformatf("tx_lane_data_o[%0d]", l), tx_lane_data_o[l],
                            scr_m ? (plain ^ key) : plain);
        end
      end
      if (m_axis_tvalid_o && m_axis_tready_i) begin
        if (exp_q.size() == 0) report_problem("output word with nothing sent");
        else compare_word("m_axis_tdata_o", m_axis_tdata_o, exp_q.pop_front());
      end
    end
  end

  task automatic write_cfg(input phy_pkg::cfg_addr_e addr, input logic [1:0] data);
    cfg_wr_i    <= 1'b1;
    cfg_addr_i  <= addr;
    cfg_wdata_i <= data;
    @(posedge clk_i);
    cfg_wr_i <= 1'b0;
    @(posedge clk_i); // lfsr restart pulse
    @(posedge clk_i);
    if (addr == phy_pkg::REG_WIDTH) width_m = (data == 2'd0) ? 1 : (data == 2'd1) ? 2 : 4;
    else scr_m = data[0];
    for (int l = 0; l < `PHY_NUM_LANES; l++) lfsr_m[l] = `PHY_LFSR_SEED;
  endtask

  task automatic check_readback(input phy_pkg::cfg_addr_e addr, input logic [1:0] exp);
    cfg_addr_i <= addr;
    @(posedge clk_i);
    compare_reg($sformatf("cfg_rdata_o[%s]", addr.name()), cfg_rdata_o, exp);
  endtask

  task automatic send_words(input int n);
    int t;
    for (int i = 0; i < n; i++) begin
      if ($urandom() % 4 == 0) begin // occasional idle cycle
        s_axis_tvalid_i <= 1'b0;
        @(posedge clk_i);
      end
      s_axis_tdata_i  <= $urandom();
      s_axis_tvalid_i <= 1'b1;
      t = 0;
      do begin
        @(posedge clk_i);
        t++;
      end while (!s_axis_tready_o && t < WAIT_LIMIT);
      if (!s_axis_tready_o) abort_run("input word never accepted");
    end
    s_axis_tvalid_i <= 1'b0;
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    do begin
      @(negedge clk_i);
      t++;
    end while ((exp_q.size() != 0 || lanes_pending() != 0) && t < WAIT_LIMIT);
    if (exp_q.size() != 0 || lanes_pending() != 0) abort_run("datapath never drained");
    @(posedge clk_i);
  endtask

  task automatic end_test(input string name, input int start);
    tests++;
    if (errors != start) begin
      failed++;
      $display("test %s: failed with %0d errors", name, errors - start);
    end else begin
      $display("test %s: passed", name);
    end
  endtask

  task automatic finish_run();
    int asrt;
    asrt = UUT.u_chk.fail_cnt;
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
             tests, failed, checks, errors, asrt);
    if (errors == 0 && failed == 0 && asrt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  initial begin
    @(abort_ev);
    finish_run();
  end

  initial begin
    int start;
    int t;
    int stall;
    void'($urandom(32'hbe93_abfa));
    for (int i = 0; i < PAT_LEN; i++) ready_pat[i] = ($urandom() % 3) != 0;
    rst_n_i         = 1'b0;
    s_axis_tdata_i  = '0;
    s_axis_tvalid_i = 1'b0;
    m_axis_tready_i = 1'b0;
    cfg_wr_i        = 1'b0;
    cfg_addr_i      = phy_pkg::REG_WIDTH;
    cfg_wdata_i     = '0;
    ready_mode      = 2'd2;
    width_m         = 4;
    scr_m           = 1'b1;
    errors          = 0;
    checks          = 0;
    tests           = 0;
    failed          = 0;
    beat_cnt        = 0;
    for (int l = 0; l < `PHY_NUM_LANES; l++) lfsr_m[l] = `PHY_LFSR_SEED;
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);

    start = errors;
    compare_flag("m_axis_tvalid_o", m_axis_tvalid_o, 1'b0);
    compare_flag("|tx_lane_valid_o", |tx_lane_valid_o, 1'b0);
    compare_flag("s_axis_tready_o", s_axis_tready_o, 1'b1);
    check_readback(phy_pkg::REG_WIDTH, phy_pkg::X4);
    check_readback(phy_pkg::REG_SCRAMBLE, 2'b01);
    end_test("reset state", start);

    start    = errors;
    beat_cnt = 0;
    ready_mode <= 2'd0;
    send_words(200);
    wait_drain();
    compare_count("tx beats at x4", beat_cnt, 200);
    end_test("loopback x4", start);

    start = errors;
    write_cfg(phy_pkg::REG_WIDTH, phy_pkg::X2);
    check_readback(phy_pkg::REG_WIDTH, phy_pkg::X2);
    beat_cnt = 0;
    send_words(60);
    wait_drain();
    compare_count("tx beats at x2", beat_cnt, 120);
    write_cfg(phy_pkg::REG_WIDTH, phy_pkg::X1);
    check_readback(phy_pkg::REG_WIDTH, phy_pkg::X1);
    beat_cnt = 0;
    send_words(60);
    wait_drain();
    compare_count("tx beats at x1", beat_cnt, 240);
    end_test("narrow widths", start);

    start = errors;
    write_cfg(phy_pkg::REG_SCRAMBLE, 2'b00);
    check_readback(phy_pkg::REG_SCRAMBLE, 2'b00);
    send_words(40);
    wait_drain();
    write_cfg(phy_pkg::REG_SCRAMBLE, 2'b01);
    write_cfg(phy_pkg::REG_WIDTH, phy_pkg::X2);
    send_words(40);
    wait_drain();
    write_cfg(phy_pkg::REG_WIDTH, phy_pkg::X4);
    send_words(40);
    wait_drain();
    end_test("scrambling", start);

    // hold the output off until the input side stalls
    start = errors;
    ready_mode      <= 2'd1;
    s_axis_tdata_i  <= $urandom();
    s_axis_tvalid_i <= 1'b1;
    stall = 0;
    t     = 0;
    while (stall < STALL_RUN && t < WAIT_LIMIT) begin
      @(posedge clk_i);
      t++;
      if (s_axis_tready_o) begin
        stall = 0;
        s_axis_tdata_i <= $urandom();
      end else begin
        stall++;
      end
    end
    if (stall < STALL_RUN) abort_run("input never stalled under back-pressure");
    compare_flag("m_axis_tvalid_o", m_axis_tvalid_o, 1'b1);
    if (exp_q.size() > `PHY_FIFO_DEPTH) report_problem("more words held than the FIFO can hold");
    ready_mode <= 2'd2;
    t = 0;
    do begin
      @(posedge clk_i);
      t++;
    end while (!s_axis_tready_o && t < WAIT_LIMIT);
    if (!s_axis_tready_o) abort_run("held input word never accepted");
    s_axis_tvalid_i <= 1'b0;
    wait_drain();
    end_test("back-pressure", start);

    repeat (4) @(posedge clk_i);
    finish_run();
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verilog
verilog/phy_pkg.sv
verilog/lane_cfg_regs.sv
verilog/lane_striper.sv
verilog/lane_scrambler.sv
verilog/lane_packer.sv
verilog/rx_fifo.sv
verilog/phy_datapath_top.sv
tb/phy_datapath_chk.sv
tb/tb_phy_datapath.sv

// File: run.sh
#!/bin/sh
# build and run the loopback testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_phy_datapath -f sim.f

out=$(./obj_dir/Vtb_phy_datapath 2>&1)
echo "$out"

if echo "$out" | grep -qx "=== PASS ==="; then
  exit 0
fi
exit 1
